//--- logic/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Datapath widths.
`define WORD_W 32
`define REG_ADDR_W 5
`define SHAMT_W 5

// Number of iterations for one MULTU or DIVU.
`define MULDIV_STEPS 32

// Exception codes reported on exc_code.
`define EXC_CODE_W 4
`define EXC_SYSCALL 4'd8
`define EXC_RESERVED 4'd10

`endif

//--- logic/cpu_pkg.sv
package cpu_pkg;

    typedef enum logic [5:0] {
        SLL     = 6'd0,
        SYSCALL = 6'd12,
        MFHI    = 6'd16,
        MTHI    = 6'd17,
        MFLO    = 6'd18,
        MTLO    = 6'd19,
        MULTU   = 6'd25,
        DIVU    = 6'd27,
        ADDU    = 6'd33
    } funct_t;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SHIFT_LEFT,
        ALU_PASS_A
    } alu_op_t;

    typedef enum logic [1:0] {
        REG_SRC_ALU,
        REG_SRC_HI,
        REG_SRC_LO
    } reg_src_t;

    typedef enum logic {
        HILO_SRC_RS,
        HILO_SRC_MULDIV
    } hilo_src_t;

    typedef enum logic [1:0] {
        MULDIV_NONE,
        MULDIV_MULTU,
        MULDIV_DIVU
    } muldiv_op_t;

    typedef enum logic [1:0] {
        EXC_NONE,
        EXC_CHK_SYSCALL,
        EXC_CHK_RESERVED
    } exc_t;

    typedef struct packed {
        alu_op_t    alu_op;
        reg_src_t   reg_src;
        logic       write_rd;
        hilo_src_t  hilo_src;
        logic       write_hi;
        logic       write_lo;
        muldiv_op_t muldiv_op;
        exc_t       exc;
    } control_t;

    // Nothing written, nothing started, no exception.
    localparam control_t CLEAR_CONTROL = '{
        alu_op:    ALU_ADD,
        reg_src:   REG_SRC_ALU,
        write_rd:  1'b0,
        hilo_src:  HILO_SRC_RS,
        write_hi:  1'b0,
        write_lo:  1'b0,
        muldiv_op: MULDIV_NONE,
        exc:       EXC_NONE
    };

endpackage

//--- logic/rtype_decoder.sv
`timescale 1ns/1ps

`include "cpu_consts.svh"

module rtype_decoder (
    input  logic [`WORD_W-1:0] instruction,
    output cpu_pkg::control_t  ctl
);

    cpu_pkg::funct_t funct;

    assign funct = cpu_pkg::funct_t'(instruction[5:0]); // Opcode bits are not looked at.

    always_comb begin
        ctl = cpu_pkg::CLEAR_CONTROL;

        case (funct)
            cpu_pkg::SLL: begin
                ctl.alu_op   = cpu_pkg::ALU_SHIFT_LEFT; // rt << shamt.
                ctl.reg_src  = cpu_pkg::REG_SRC_ALU;
                ctl.write_rd = 1'b1;
            end

            cpu_pkg::ADDU: begin
                ctl.alu_op   = cpu_pkg::ALU_ADD; // Wraps without an overflow trap.
                ctl.reg_src  = cpu_pkg::REG_SRC_ALU;
                ctl.write_rd = 1'b1;
            end

            cpu_pkg::MFHI: begin
                ctl.reg_src  = cpu_pkg::REG_SRC_HI;
                ctl.write_rd = 1'b1;
            end

            cpu_pkg::MFLO: begin
                ctl.reg_src  = cpu_pkg::REG_SRC_LO;
                ctl.write_rd = 1'b1;
            end

            cpu_pkg::MTHI: begin
                ctl.hilo_src = cpu_pkg::HILO_SRC_RS;
                ctl.write_hi = 1'b1;
            end

            cpu_pkg::MTLO: begin
                ctl.hilo_src = cpu_pkg::HILO_SRC_RS;
                ctl.write_lo = 1'b1;
            end

            cpu_pkg::MULTU: begin
                ctl.muldiv_op = cpu_pkg::MULDIV_MULTU;
                ctl.hilo_src  = cpu_pkg::HILO_SRC_MULDIV;
                ctl.write_hi  = 1'b1;
                ctl.write_lo  = 1'b1;
            end

            cpu_pkg::DIVU: begin
                ctl.muldiv_op = cpu_pkg::MULDIV_DIVU;
                ctl.hilo_src  = cpu_pkg::HILO_SRC_MULDIV;
                ctl.write_hi  = 1'b1;
                ctl.write_lo  = 1'b1;
            end

            cpu_pkg::SYSCALL: begin
                ctl.exc = cpu_pkg::EXC_CHK_SYSCALL;
            end

            default: begin
                ctl.exc = cpu_pkg::EXC_CHK_RESERVED; // Unknown funct.
            end
        endcase
    end

endmodule

//--- logic/exec_control.sv
`timescale 1ns/1ps

`include "cpu_consts.svh"

module exec_control (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    instr_valid,
    input  logic [`WORD_W-1:0]      instruction,
    input  logic                    md_done,
    output logic                    busy,
    output cpu_pkg::alu_op_t        alu_op,
    output cpu_pkg::reg_src_t       reg_src,
    output logic                    rd_we,
    output logic [`REG_ADDR_W-1:0]  rd_addr,
    output logic                    hi_we,
    output logic                    lo_we,
    output cpu_pkg::hilo_src_t      hilo_src,
    output logic                    md_start,
    output cpu_pkg::muldiv_op_t     md_op,
    output logic                    exc_valid,
    output logic [`EXC_CODE_W-1:0]  exc_code
);

    cpu_pkg::control_t ctl;
    logic              accept;
    logic              is_muldiv;

    rtype_decoder u_decoder (
        .instruction (instruction),
        .ctl         (ctl)
    );

    assign accept    = instr_valid && !busy; // Words offered while busy are dropped.
    assign is_muldiv = (ctl.muldiv_op != cpu_pkg::MULDIV_NONE);

    assign alu_op  = ctl.alu_op;
    assign reg_src = ctl.reg_src;
    assign rd_addr = instruction[15:11];
    assign rd_we   = accept && ctl.write_rd;

    // Moves write HI/LO at once; MULTU and DIVU write both when the unit finishes.
    assign hi_we    = (accept && ctl.write_hi && !is_muldiv) || md_done;
    assign lo_we    = (accept && ctl.write_lo && !is_muldiv) || md_done;
    assign hilo_src = md_done ? cpu_pkg::HILO_SRC_MULDIV : ctl.hilo_src;

    assign md_start = accept && is_muldiv;
    assign md_op    = ctl.muldiv_op;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (md_start) begin
            busy <= 1'b1;
        end else if (md_done) begin
            busy <= 1'b0; // HI and LO take the result on this same edge.
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            exc_valid <= 1'b0;
            exc_code  <= '0;
        end else begin
            exc_valid <= accept && (ctl.exc != cpu_pkg::EXC_NONE);
            if (ctl.exc == cpu_pkg::EXC_CHK_SYSCALL) begin
                exc_code <= `EXC_SYSCALL;
            end else begin
                exc_code <= `EXC_RESERVED;
            end
        end
    end

endmodule

//--- logic/reg_file.sv
`timescale 1ns/1ps

`include "cpu_consts.svh"

module reg_file (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`REG_ADDR_W-1:0]  rs_addr,
    input  logic [`REG_ADDR_W-1:0]  rt_addr,
    input  logic                    rd_we,
    input  logic [`REG_ADDR_W-1:0]  rd_addr,
    input  cpu_pkg::reg_src_t       reg_src,
    input  logic [`WORD_W-1:0]      alu_result,
    input  logic [`WORD_W-1:0]      hi,
    input  logic [`WORD_W-1:0]      lo,
    input  logic                    host_we,
    input  logic [`REG_ADDR_W-1:0]  host_addr,
    input  logic [`WORD_W-1:0]      host_data,
    input  logic [`REG_ADDR_W-1:0]  dbg_addr,
    output logic [`WORD_W-1:0]      rs_data,
    output logic [`WORD_W-1:0]      rt_data,
    output logic [`WORD_W-1:0]      dbg_data
);

    logic [`WORD_W-1:0] regs [2**`REG_ADDR_W];
    logic [`WORD_W-1:0] wr_data;

    always_comb begin
        case (reg_src)
            cpu_pkg::REG_SRC_HI: wr_data = hi;
            cpu_pkg::REG_SRC_LO: wr_data = lo;
            default:             wr_data = alu_result;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**`REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (host_we && host_addr != '0) begin
                regs[host_addr] <= host_data;
            end
            if (rd_we && rd_addr != '0) begin
                regs[rd_addr] <= wr_data; // Later assignment, so the core port wins.
            end
        end
    end

    // Register 0 is never written, so it keeps its reset value of zero.
    assign rs_data  = regs[rs_addr];
    assign rt_data  = regs[rt_addr];
    assign dbg_data = regs[dbg_addr];

endmodule

//--- logic/alu.sv
`timescale 1ns/1ps

`include "cpu_consts.svh"

module alu (
    input  cpu_pkg::alu_op_t     alu_op,
    input  logic [`WORD_W-1:0]   a,
    input  logic [`WORD_W-1:0]   b,
    input  logic [`SHAMT_W-1:0]  shamt,
    output logic [`WORD_W-1:0]   result
);

    always_comb begin
        case (alu_op)
            cpu_pkg::ALU_ADD: begin
                result = a + b; // Carry out is dropped.
            end
            cpu_pkg::ALU_SHIFT_LEFT: begin
                result = b << shamt;
            end
            cpu_pkg::ALU_PASS_A: begin
                result = a;
            end
            default: begin
                result = a + b;
            end
        endcase
    end

endmodule

//--- logic/muldiv_unit.sv
`timescale 1ns/1ps

`include "cpu_consts.svh"

module muldiv_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  cpu_pkg::muldiv_op_t   op,
    input  logic [`WORD_W-1:0]    a,
    input  logic [`WORD_W-1:0]    b,
    output logic                  done,
    output logic [`WORD_W-1:0]    res_hi,
    output logic [`WORD_W-1:0]    res_lo
);

    localparam int CNT_W = $clog2(`MULDIV_STEPS);

    logic                 running;
    logic [CNT_W-1:0]     count;
    logic                 last_step;
    cpu_pkg::muldiv_op_t  op_q;
    logic [`WORD_W-1:0]   operand;  // Multiplicand or divisor.
    logic [`WORD_W-1:0]   acc_hi;   // Upper product half, or partial remainder.
    logic [`WORD_W-1:0]   acc_lo;   // Multiplier bits, or dividend becoming quotient.
    logic [`WORD_W:0]     mul_sum;
    logic [`WORD_W:0]     div_shift;
    logic [`WORD_W:0]     div_diff;

    assign last_step = running && (count == CNT_W'(`MULDIV_STEPS - 1));

    always_comb begin
        mul_sum   = {1'b0, acc_hi} + (acc_lo[0] ? {1'b0, operand} : '0);
        div_shift = {acc_hi, acc_lo[`WORD_W-1]};
        div_diff  = div_shift - {1'b0, operand}; // Top bit set means no subtract.
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            count   <= '0;
            done    <= 1'b0;
            op_q    <= cpu_pkg::MULDIV_NONE;
        end else begin
            done <= last_step; // One-cycle pulse after the final step.
            if (start) begin
                running <= 1'b1;
                count   <= '0;
                op_q    <= op;
            end else if (running) begin
                count <= count + 1'b1;
                if (last_step) begin
                    running <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            operand <= b;
            acc_hi  <= '0;
            acc_lo  <= a;
        end else if (running) begin
            if (op_q == cpu_pkg::MULDIV_DIVU) begin
                if (!div_diff[`WORD_W]) begin
                    acc_hi <= div_diff[`WORD_W-1:0];
                    acc_lo <= {acc_lo[`WORD_W-2:0], 1'b1};
                end else begin
                    acc_hi <= div_shift[`WORD_W-1:0]; // Restore.
                    acc_lo <= {acc_lo[`WORD_W-2:0], 1'b0};
                end
            end else begin
                acc_hi <= mul_sum[`WORD_W:1]; // Add, then shift the pair right.
                acc_lo <= {mul_sum[0], acc_lo[`WORD_W-1:1]};
            end
        end
    end

    // A zero divisor always subtracts, so quotient is all ones and remainder the dividend.
    assign res_hi = acc_hi;
    assign res_lo = acc_lo;

endmodule

//--- logic/hilo_regs.sv
`timescale 1ns/1ps

`include "cpu_consts.svh"

module hilo_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  hi_we,
    input  logic                  lo_we,
    input  cpu_pkg::hilo_src_t    hilo_src,
    input  logic [`WORD_W-1:0]    rs_data,
    input  logic [`WORD_W-1:0]    md_hi,
    input  logic [`WORD_W-1:0]    md_lo,
    output logic [`WORD_W-1:0]    hi,
    output logic [`WORD_W-1:0]    lo
);

    logic use_md;

    assign use_md = (hilo_src == cpu_pkg::HILO_SRC_MULDIV);

    always_ff @(posedge clk) begin
        if (rst) begin
            hi <= '0;
            lo <= '0;
        end else begin
            if (hi_we) begin
                hi <= use_md ? md_hi : rs_data; // Remainder or upper product word.
            end
            if (lo_we) begin
                lo <= use_md ? md_lo : rs_data;
            end
        end
    end

endmodule

//--- logic/rtype_core.sv
`timescale 1ns/1ps

`include "cpu_consts.svh"

module rtype_core (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    instr_valid,
    input  logic [`WORD_W-1:0]      instruction,
    input  logic                    host_we,
    input  logic [`REG_ADDR_W-1:0]  host_addr,
    input  logic [`WORD_W-1:0]      host_data,
    input  logic [`REG_ADDR_W-1:0]  dbg_addr,
    output logic                    busy,
    output logic                    exc_valid,
    output logic [`EXC_CODE_W-1:0]  exc_code,
    output logic [`WORD_W-1:0]      dbg_data,
    output logic [`WORD_W-1:0]      hi,
    output logic [`WORD_W-1:0]      lo
);

    cpu_pkg::alu_op_t        alu_op;
    cpu_pkg::reg_src_t       reg_src;
    cpu_pkg::hilo_src_t      hilo_src;
    cpu_pkg::muldiv_op_t     md_op;
    logic                    rd_we;
    logic [`REG_ADDR_W-1:0]  rd_addr;
    logic                    hi_we;
    logic                    lo_we;
    logic                    md_start;
    logic                    md_done;
    logic [`WORD_W-1:0]      rs_data;
    logic [`WORD_W-1:0]      rt_data;
    logic [`WORD_W-1:0]      alu_result;
    logic [`WORD_W-1:0]      md_hi;
    logic [`WORD_W-1:0]      md_lo;

    exec_control u_exec_control (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instruction (instruction),
        .md_done     (md_done),
        .busy        (busy),
        .alu_op      (alu_op),
        .reg_src     (reg_src),
        .rd_we       (rd_we),
        .rd_addr     (rd_addr),
        .hi_we       (hi_we),
        .lo_we       (lo_we),
        .hilo_src    (hilo_src),
        .md_start    (md_start),
        .md_op       (md_op),
        .exc_valid   (exc_valid),
        .exc_code    (exc_code)
    );

    reg_file u_reg_file (
        .clk        (clk),
        .rst        (rst),
        .rs_addr    (instruction[25:21]),
        .rt_addr    (instruction[20:16]),
        .rd_we      (rd_we),
        .rd_addr    (rd_addr),
        .reg_src    (reg_src),
        .alu_result (alu_result),
        .hi         (hi),
        .lo         (lo),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_data  (host_data),
        .dbg_addr   (dbg_addr),
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .dbg_data   (dbg_data)
    );

    alu u_alu (
        .alu_op (alu_op),
        .a      (rs_data),
        .b      (rt_data),
        .shamt  (instruction[10:6]),
        .result (alu_result)
    );

    hilo_regs u_hilo_regs (
        .clk      (clk),
        .rst      (rst),
        .hi_we    (hi_we),
        .lo_we    (lo_we),
        .hilo_src (hilo_src),
        .rs_data  (rs_data),
        .md_hi    (md_hi),
        .md_lo    (md_lo),
        .hi       (hi),
        .lo       (lo)
    );

    muldiv_unit u_muldiv_unit (
        .clk    (clk),
        .rst    (rst),
        .start  (md_start),
        .op     (md_op),
        .a      (rs_data),
        .b      (rt_data),
        .done   (md_done),
        .res_hi (md_hi),
        .res_lo (md_lo)
    );

endmodule

//--- test/tb_rtype_core.sv
`timescale 1ns/1ps

`include "cpu_consts.svh"

module tb_rtype_core;

    localparam int RESET_CYCLES = 16;
    localparam int N_ISSUES     = 27;
    localparam int N_LOADS      = 34;
    localparam int N_READS      = 75;
    // Every issue may run a full multiply or divide. Loads and reads take two cycles at most.
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + N_ISSUES * (`MULDIV_STEPS + 4)
                                    + (N_LOADS + N_READS) * 2 + 20;

    logic                    clk;
    logic                    rst;
    logic                    instr_valid;
    logic [`WORD_W-1:0]      instruction;
    logic                    host_we;
    logic [`REG_ADDR_W-1:0]  host_addr;
    logic [`WORD_W-1:0]      host_data;
    logic [`REG_ADDR_W-1:0]  dbg_addr;
    logic                    busy;
    logic                    exc_valid;
    logic [3:0]              exc_code;
    logic [`WORD_W-1:0]      dbg_data;
    logic [`WORD_W-1:0]      hi;
    logic [`WORD_W-1:0]      lo;

    logic [`WORD_W-1:0] model_regs [32]; // Expected register file contents.
    logic [`WORD_W-1:0] model_hi;
    logic [`WORD_W-1:0] model_lo;
    integer             seed;
    int                 pass_count;
    int                 error_count;
    int                 cycle_count;

    rtype_core dut0 (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instruction (instruction),
        .host_we     (host_we),
        .host_addr   (host_addr),
        .host_data   (host_data),
        .dbg_addr    (dbg_addr),
        .busy        (busy),
        .exc_valid   (exc_valid),
        .exc_code    (exc_code),
        .dbg_data    (dbg_data),
        .hi          (hi),
        .lo          (lo)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d clock cycles.",
                     TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] time %0t: %s expected 0x%08h, got 0x%08h",
                     $time, name, expected, actual);
        end else begin
            pass_count++;
        end
    endtask

    // Inputs change 2 ns after a rising edge.
    task automatic wait_slot();
        @(posedge clk);
        #2;
    endtask

    task automatic load_reg(input logic [4:0] addr, input logic [31:0] data);
        wait_slot();
        host_we   = 1'b1;
        host_addr = addr;
        host_data = data;
        wait_slot();
        host_we = 1'b0;
        if (addr != 5'd0) begin
            model_regs[addr] = data; // Register 0 ignores writes.
        end
    endtask

    task automatic read_reg(input logic [4:0] addr, output logic [31:0] value);
        wait_slot();
        dbg_addr = addr;
        #1;
        value = dbg_data;
    endtask

    // Returns one slot after the accepting edge, once busy is low again.
    task automatic issue(input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] rd,
                         input logic [4:0] shamt, input logic [5:0] funct,
                         output logic saw_busy);
        wait_slot();
        instruction = {6'd0, rs, rt, rd, shamt, funct};
        instr_valid = 1'b1;
        wait_slot();
        instr_valid = 1'b0;
        saw_busy    = busy;
        while (busy) begin
            wait_slot();
        end
    endtask

    task automatic reset_state_test();
        int          errs_before;
        logic [31:0] value;
        errs_before = error_count;
        compare("busy", 32'd0, {31'd0, busy});
        compare("exc_valid", 32'd0, {31'd0, exc_valid});
        compare("hi", 32'd0, hi);
        compare("lo", 32'd0, lo);
        for (int i = 0; i < 32; i++) begin
            read_reg(i, value);
            compare("dbg_data", 32'd0, value);
        end
        $display("reset_state_test finished with %0d errors", error_count - errs_before);
    endtask

    task automatic addu_sll_test();
        int          errs_before;
        logic [31:0] value;
        logic [4:0]  shamt;
        logic        saw_busy;
        errs_before = error_count;
        for (int i = 1; i <= 8; i++) begin
            load_reg(i, $random(seed));
        end
        for (int i = 0; i < 4; i++) begin
            issue(i + 1, i + 5, i + 10, 5'd0, cpu_pkg::ADDU, saw_busy);
            model_regs[i + 10] = model_regs[i + 1] + model_regs[i + 5]; // Wraps at 2^32.
            read_reg(i + 10, value);
            compare("dbg_data after ADDU", model_regs[i + 10], value);
        end
        for (int i = 0; i < 4; i++) begin
            shamt = $random(seed);
            issue(5'd0, i + 1, i + 14, shamt, cpu_pkg::SLL, saw_busy);
            model_regs[i + 14] = model_regs[i + 1] << shamt;
            read_reg(i + 14, value);
            compare("dbg_data after SLL", model_regs[i + 14], value);
        end
        issue(5'd1, 5'd2, 5'd0, 5'd0, cpu_pkg::ADDU, saw_busy);
        read_reg(5'd0, value);
        compare("dbg_data of register 0", 32'd0, value);
        $display("addu_sll_test finished with %0d errors", error_count - errs_before);
    endtask

    task automatic hilo_move_test();
        int          errs_before;
        logic [31:0] value;
        logic        saw_busy;
        errs_before = error_count;
        load_reg(5'd20, $random(seed));
        load_reg(5'd21, $random(seed));
        issue(5'd20, 5'd0, 5'd0, 5'd0, cpu_pkg::MTHI, saw_busy);
        model_hi = model_regs[20];
        compare("hi after MTHI", model_hi, hi);
        compare("lo after MTHI", model_lo, lo);
        issue(5'd21, 5'd0, 5'd0, 5'd0, cpu_pkg::MTLO, saw_busy);
        model_lo = model_regs[21];
        compare("lo after MTLO", model_lo, lo);
        compare("hi after MTLO", model_hi, hi);
        issue(5'd0, 5'd0, 5'd22, 5'd0, cpu_pkg::MFHI, saw_busy);
        model_regs[22] = model_hi;
        read_reg(5'd22, value);
        compare("dbg_data after MFHI", model_regs[22], value);
        issue(5'd0, 5'd0, 5'd23, 5'd0, cpu_pkg::MFLO, saw_busy);
        model_regs[23] = model_lo;
        read_reg(5'd23, value);
        compare("dbg_data after MFLO", model_regs[23], value);
        $display("hilo_move_test finished with %0d errors", error_count - errs_before);
    endtask

    task automatic multu_test();
        int          errs_before;
        logic [31:0] op_a [6];
        logic [31:0] op_b [6];
        logic [63:0] product;
        logic        saw_busy;
        errs_before = error_count;
        for (int i = 0; i < 4; i++) begin
            op_a[i] = $random(seed);
            op_b[i] = $random(seed);
        end
        op_a[4] = 32'hffff_ffff; // Largest possible product.
        op_b[4] = 32'hffff_ffff;
        op_a[5] = 32'd0;
        op_b[5] = $random(seed);
        for (int i = 0; i < 6; i++) begin
            load_reg(5'd24, op_a[i]);
            load_reg(5'd25, op_b[i]);
            issue(5'd24, 5'd25, 5'd0, 5'd0, cpu_pkg::MULTU, saw_busy);
            product  = {32'd0, op_a[i]} * {32'd0, op_b[i]};
            model_hi = product[63:32];
            model_lo = product[31:0];
            compare("busy after MULTU accept", 32'd1, {31'd0, saw_busy});
            compare("hi after MULTU", model_hi, hi);
            compare("lo after MULTU", model_lo, lo);
        end
        $display("multu_test finished with %0d errors", error_count - errs_before);
    endtask

    task automatic divu_test();
        int          errs_before;
        logic [31:0] op_a [6];
        logic [31:0] op_b [6];
        logic        saw_busy;
        errs_before = error_count;
        for (int i = 0; i < 4; i++) begin
            op_a[i] = $random(seed);
            op_b[i] = $random(seed);
            op_b[i] = op_b[i] >> (8 * i); // Smaller divisors give larger quotients.
        end
        op_a[4] = $random(seed);
        op_b[4] = 32'd0;
        op_a[5] = 32'hffff_ffff;
        op_b[5] = 32'd7;
        for (int i = 0; i < 6; i++) begin
            load_reg(5'd26, op_a[i]);
            load_reg(5'd27, op_b[i]);
            issue(5'd26, 5'd27, 5'd0, 5'd0, cpu_pkg::DIVU, saw_busy);
            if (op_b[i] == 32'd0) begin
                model_lo = 32'hffff_ffff;
                model_hi = op_a[i];
            end else begin
                model_lo = op_a[i] / op_b[i];
                model_hi = op_a[i] % op_b[i];
            end
            compare("busy after DIVU accept", 32'd1, {31'd0, saw_busy});
            compare("lo (quotient)", model_lo, lo);
            compare("hi (remainder)", model_hi, hi);
        end
        $display("divu_test finished with %0d errors", error_count - errs_before);
    endtask

    task automatic exception_test();
        int          errs_before;
        logic [31:0] value;
        logic        saw_busy;
        errs_before = error_count;
        issue(5'd1, 5'd2, 5'd10, 5'd0, cpu_pkg::SYSCALL, saw_busy);
        compare("exc_valid after SYSCALL", 32'd1, {31'd0, exc_valid});
        compare("exc_code after SYSCALL", 32'd8, {28'd0, exc_code});
        wait_slot();
        compare("exc_valid one cycle later", 32'd0, {31'd0, exc_valid});
        issue(5'd3, 5'd4, 5'd11, 5'd0, 6'd63, saw_busy); // Funct 63 is not implemented.
        compare("exc_valid after funct 63", 32'd1, {31'd0, exc_valid});
        compare("exc_code after funct 63", 32'd10, {28'd0, exc_code});
        wait_slot();
        compare("exc_valid one cycle later", 32'd0, {31'd0, exc_valid});
        compare("hi", model_hi, hi);
        compare("lo", model_lo, lo);
        for (int i = 0; i < 32; i++) begin
            read_reg(i, value);
            compare("dbg_data after exceptions", model_regs[i], value);
        end
        $display("exception_test finished with %0d errors", error_count - errs_before);
    endtask

    initial begin
        seed        = 56130;
        pass_count  = 0;
        error_count = 0;
        cycle_count = 0;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instruction = '0;
        host_we     = 1'b0;
        host_addr   = '0;
        host_data   = '0;
        dbg_addr    = '0;
        model_hi    = '0;
        model_lo    = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;

        reset_state_test();
        addu_sll_test();
        hilo_move_test();
        multu_test();
        divu_test();
        exception_test();

        $display("Checks passed: %0d, errors: %0d", pass_count, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+logic
logic/cpu_pkg.sv
logic/rtype_decoder.sv
logic/exec_control.sv
logic/reg_file.sv
logic/alu.sv
logic/muldiv_unit.sv
logic/hilo_regs.sv
logic/rtype_core.sv
test/tb_rtype_core.sv

//--- Bender.yml
package:
  name: rtype_core

sources:
  - include_dirs:
      - logic
    files:
      - logic/cpu_pkg.sv
      - logic/rtype_decoder.sv
      - logic/exec_control.sv
      - logic/reg_file.sv
      - logic/alu.sv
      - logic/muldiv_unit.sv
      - logic/hilo_regs.sv
      - logic/rtype_core.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/tb_rtype_core.sv
